/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_dcache.sv */
// single requester; memory answers within 8 cycles; 4 tags over 8 indices so conflicts are frequent
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache;

    localparam logic [31:0]      SEED              = 32'h75dd_db2b;
    localparam int               N_RANDOM          = 400;
    localparam int               MAX_RANDOM_FENCES = 16;
    localparam int               N_OPS             = N_RANDOM + 60;
    localparam int               FENCE_CYCLES      = 1024; // walk plus a few write-backs
    localparam int               RESP_LIMIT        = FENCE_CYCLES;
    localparam int               WATCHDOG_CYCLES   = 16 + N_OPS * 40 +
                                                     (MAX_RANDOM_FENCES + 4) * FENCE_CYCLES;
    localparam dcache_pkg::tag_t TAG_BASE          = 52'h3_a5c0_0f00_1000;

    logic               clk;
    logic               rst;
    logic               req_valid_i;
    logic               req_we_i;
    logic               req_fence_i;
    dcache_pkg::addr_t  req_addr_i;
    dcache_pkg::word_t  req_wdata_i;
    dcache_pkg::wmask_t req_wmask_i;
    logic               resp_ready_o;
    dcache_pkg::word_t  resp_rdata_o;
    logic               idle_o;
    logic               mem_valid_o;
    logic               mem_we_o;
    dcache_pkg::addr_t  mem_addr_o;
    dcache_pkg::line_t  mem_wdata_o;
    logic               mem_ready_i;
    dcache_pkg::line_t  mem_rdata_i;

    logic [31:0]        stim_rng;
    logic [31:0]        delay_rng;
    int                 err_cnt = 0;
    int                 test_no = 0;
    int                 test_err0 = 0;
    int                 tests_bad = 0;

    dcache_pkg::line_t  ref_mem   [dcache_pkg::addr_t]; // processor view of memory
    dcache_pkg::line_t  mem_store [dcache_pkg::addr_t]; // what the memory really holds
    logic               c_valid   [`DC_NLINES];
    logic               c_dirty   [`DC_NLINES];
    dcache_pkg::tag_t   c_tag     [`DC_NLINES];
    logic               exp_we_q   [$];
    dcache_pkg::addr_t  exp_addr_q [$];
    dcache_pkg::line_t  exp_data_q [$];

    dcache_top UUT (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_fence_i  (req_fence_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_wmask_i  (req_wmask_i),
        .resp_ready_o (resp_ready_o),
        .resp_rdata_o (resp_rdata_o),
        .idle_o       (idle_o),
        .mem_valid_o  (mem_valid_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // contents of a line nobody has written yet
    function automatic dcache_pkg::line_t line_hash(input dcache_pkg::addr_t a);
        dcache_pkg::word_t h;
        h = a * 64'h9e37_79b9_7f4a_7c15;
        return {h ^ 64'h5bd1_e995_3c6e_f372, ~h};
    endfunction

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return line_hash(a);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::wmask_t mask);
        dcache_pkg::word_t w;
        w = old_w;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (mask[b]) w[b * 8 +: 8] = new_w[b * 8 +: 8];
        end
        return w;
    endfunction

    // slot spreads 8 indices over all four banks
    function automatic dcache_pkg::addr_t make_addr(input logic [1:0] t, input logic [2:0] slot,
                                                    input logic sel);
        dcache_pkg::tag_t   tg;
        dcache_pkg::index_t idx;
        tg  = TAG_BASE | dcache_pkg::tag_t'(t);
        idx = {slot[2:1], 5'b0, slot[0]};
        return {tg, idx, sel, 3'b000};
    endfunction

    task automatic draw(output logic [31:0] r);
        stim_rng = xorshift(stim_rng);
        r = stim_rng;
    endtask

    task automatic report_mismatch(input string name, input dcache_pkg::line_t got,
                                   input dcache_pkg::line_t exp);
        $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("error: %s at %0t", msg, $time);
        err_cnt++;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (err_cnt == test_err0) begin
            $display("test %0d, %s: ok", test_no, name);
        end else begin
            tests_bad++;
            $display("test %0d, %s: %0d errors", test_no, name, err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    task automatic push_expect(input logic we, input dcache_pkg::addr_t a,
                               input dcache_pkg::line_t d);
        exp_we_q.push_back(we);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
    endtask

    // direct-mapped cache model, queues the memory traffic a request must cause
    task automatic predict_access(input dcache_pkg::addr_t addr, input logic we,
                                  output logic hit);
        dcache_pkg::index_t idx;
        dcache_pkg::tag_t   tg;
        dcache_pkg::addr_t  victim;
        idx = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        tg  = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        hit = c_valid[idx] && (c_tag[idx] == tg);
        if (!hit) begin
            if (c_valid[idx] && c_dirty[idx]) begin
                victim = {c_tag[idx], idx, 4'h0};
                push_expect(1'b1, victim, ref_line(victim));
            end
            push_expect(1'b0, {tg, idx, 4'h0}, '0);
            c_valid[idx] = 1'b1;
            c_tag[idx]   = tg;
            c_dirty[idx] = 1'b0;
        end
        if (we) c_dirty[idx] = 1'b1;
    endtask

    task automatic predict_fence();
        dcache_pkg::addr_t a;
        for (int i = 0; i < `DC_NLINES; i++) begin
            if (c_valid[i] && c_dirty[i]) begin
                a = {c_tag[i], dcache_pkg::index_t'(i), 4'h0};
                push_expect(1'b1, a, ref_line(a));
                c_dirty[i] = 1'b0;
            end
        end
    endtask

    task automatic check_drained();
        if (exp_addr_q.size() != 0) begin
            report_problem($sformatf("%0d expected memory accesses never happened",
                                     exp_addr_q.size()));
            exp_we_q.delete();
            exp_addr_q.delete();
            exp_data_q.delete();
        end
    endtask

    // fields stay put after the response, a write still merges in WRITE_IN
    task automatic issue(input logic we, input logic fence, input dcache_pkg::addr_t addr,
                         input dcache_pkg::word_t wdata, input dcache_pkg::wmask_t mask,
                         output int lat);
        while (!(idle_o === 1'b1 && resp_ready_o === 1'b0)) begin
            @(posedge clk);
            #1;
        end
        req_valid_i = 1'b1;
        req_we_i    = we;
        req_fence_i = fence;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_wmask_i = mask;
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (resp_ready_o !== 1'b1 && lat < RESP_LIMIT);
        if (resp_ready_o !== 1'b1) report_problem("cache gave no response in time");
        req_valid_i = 1'b0;
        req_fence_i = 1'b0;
    endtask

    task automatic access(input logic we, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::wmask_t mask);
        logic              hit;
        int                lat;
        dcache_pkg::addr_t line_a;
        dcache_pkg::line_t line;
        dcache_pkg::word_t old_w;
        line_a = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], 4'h0};
        predict_access(addr, we, hit);
        issue(we, 1'b0, addr, wdata, mask, lat);
        line  = ref_line(line_a);
        old_w = addr[3] ? line[`DC_LINE_W-1 -: `DC_WORD_W] : line[`DC_WORD_W-1:0];
        if (we) begin
            if (addr[3]) line[`DC_LINE_W-1 -: `DC_WORD_W] = merge_bytes(old_w, wdata, mask);
            else line[`DC_WORD_W-1:0] = merge_bytes(old_w, wdata, mask);
            ref_mem[line_a] = line;
        end else if (resp_rdata_o !== old_w) begin
            report_mismatch("resp_rdata_o", dcache_pkg::line_t'(resp_rdata_o),
                            dcache_pkg::line_t'(old_w));
        end
        if (hit && lat != 3) begin
            report_problem($sformatf("hit at %h answered after %0d cycles, not 3", addr, lat));
        end
        check_drained();
    endtask

    task automatic run_fence();
        int lat;
        predict_fence();
        issue(1'b0, 1'b1, '0, '0, '0, lat);
        check_drained();
    endtask

    task automatic check_memory_request();
        logic              e_we;
        dcache_pkg::addr_t e_addr;
        dcache_pkg::line_t e_data;
        if (exp_addr_q.size() == 0) begin
            report_problem($sformatf("unexpected memory %s at %h",
                                     mem_we_o ? "write" : "read", mem_addr_o));
        end else begin
            e_we   = exp_we_q.pop_front();
            e_addr = exp_addr_q.pop_front();
            e_data = exp_data_q.pop_front();
            if (mem_we_o !== e_we) begin
                report_mismatch("mem_we_o", dcache_pkg::line_t'(mem_we_o),
                                dcache_pkg::line_t'(e_we));
            end
            if (mem_addr_o !== e_addr) begin
                report_mismatch("mem_addr_o", dcache_pkg::line_t'(mem_addr_o),
                                dcache_pkg::line_t'(e_addr));
            end
            if (e_we && mem_wdata_o !== e_data) begin
                report_mismatch("mem_wdata_o", mem_wdata_o, e_data);
            end
        end
    endtask

    // line memory, ready after 1 to 8 cycles
    initial begin : memory_model
        int delay;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        delay_rng   = ~SEED;
        forever begin
            @(posedge clk);
            #1;
            if (mem_valid_o === 1'b1) begin
                delay_rng = xorshift(delay_rng);
                delay = int'(delay_rng[2:0]) + 1;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                check_memory_request();
                if (mem_we_o) mem_store[mem_addr_o] = mem_wdata_o;
                else if (mem_store.exists(mem_addr_o)) mem_rdata_i = mem_store[mem_addr_o];
                else mem_rdata_i = line_hash(mem_addr_o);
                mem_ready_i = 1'b1;
                @(posedge clk);
                #1;
                mem_ready_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        logic [31:0]       r;
        logic [31:0]       r2;
        logic [31:0]       r3;
        dcache_pkg::addr_t a;
        int                n_fence;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_fence_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wmask_i = '0;
        stim_rng    = SEED;
        n_fence     = 0;
        for (int i = 0; i < `DC_NLINES; i++) begin
            c_valid[i] = 1'b0;
            c_dirty[i] = 1'b0;
            c_tag[i]   = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        if (resp_ready_o !== 1'b0) begin
            report_mismatch("resp_ready_o", dcache_pkg::line_t'(resp_ready_o), '0);
        end
        if (mem_valid_o !== 1'b0) begin
            report_mismatch("mem_valid_o", dcache_pkg::line_t'(mem_valid_o), '0);
        end
        if (idle_o !== 1'b1) begin
            report_mismatch("idle_o", dcache_pkg::line_t'(idle_o), 128'h1);
        end
        finish_test("reset state");

        a = make_addr(2'd0, 3'd1, 1'b1);
        access(1'b0, a, '0, '0);
        access(1'b0, a, '0, '0); // now a hit
        finish_test("read miss then hit");

        repeat (12) begin
            draw(r);
            draw(r2);
            draw(r3);
            a = make_addr(r[1:0], r[4:2], r[5]);
            access(1'b1, a, {r2, r3}, r[15:8]);
            access(1'b0, a, '0, '0);
            access(1'b0, a ^ 64'h8, '0, '0); // other word of the line
        end
        finish_test("masked writes");

        a = make_addr(2'd1, 3'd6, 1'b0);
        access(1'b1, a, 64'h0123_4567_89ab_cdef, 8'hff);
        access(1'b0, make_addr(2'd2, 3'd6, 1'b1), '0, '0); // evicts the dirty line
        access(1'b0, a, '0, '0);
        finish_test("dirty victim write-back");

        access(1'b1, make_addr(2'd3, 3'd0, 1'b0), 64'h1111_2222_3333_4444, 8'h0f);
        access(1'b1, make_addr(2'd3, 3'd7, 1'b1), 64'h5555_6666_7777_8888, 8'hf0);
        access(1'b1, make_addr(2'd0, 3'd3, 1'b0), 64'h9999_aaaa_bbbb_cccc, 8'h3c);
        run_fence();
        run_fence(); // nothing dirty left
        access(1'b0, make_addr(2'd3, 3'd7, 1'b1), '0, '0);
        finish_test("fence write-back");

        for (int n = 0; n < N_RANDOM; n++) begin
            draw(r);
            if (r[31:27] == 5'd0 && n_fence < MAX_RANDOM_FENCES) begin
                run_fence();
                n_fence++;
            end else begin
                draw(r2);
                draw(r3);
                access(r[30], make_addr(r[1:0], r[4:2], r[5]), {r2, r3}, r[15:8]);
            end
        end
        finish_test("random mix");

        $display("tests run %0d, tests with errors %0d, errors %0d", test_no, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/dcache_pkg.sv
source/dcache_ifs.sv
source/dcache_sram_bank.sv
source/dcache_tag_store.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
dv/tb_dcache.sv

/* source/dcache_ctrl.sv */
// one request at a time; request fields must stay stable until resp_ready_o, memory holds off with mem_ready_i only
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req_valid_i,
    input  wire logic                req_we_i,
    input  wire logic                req_fence_i,
    input  wire dcache_pkg::tag_t    req_tag_i,
    input  wire dcache_pkg::index_t  req_index_i,
    output      logic                resp_ready_o,
    output      dcache_pkg::word_t   resp_rdata_o,
    output      logic                idle_o,
    output      logic                mem_valid_o,
    output      logic                mem_we_o,
    output      dcache_pkg::addr_t   mem_addr_o,
    output      dcache_pkg::line_t   mem_wdata_o,
    input  wire logic                mem_ready_i,
    meta_if.ctrl                     meta,
    line_if.ctrl                     lines
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    dcache_pkg::index_t      walk_cnt;
    dcache_pkg::index_t      cur_index;
    logic                    fence_walk;
    logic                    victim_dirty;
    logic                    line_done;
    logic                    walk_last;

    assign fence_walk   = (state_q == dcache_pkg::FLUSH) || (state_q == dcache_pkg::FLUSH_NEXT);
    assign cur_index    = fence_walk ? walk_cnt : req_index_i;
    assign victim_dirty = meta.victim_valid && meta.victim_dirty;
    assign line_done    = !victim_dirty || mem_ready_i; // clean lines skip the memory
    assign walk_last    = (walk_cnt == {`DC_INDEX_W{1'b1}});

    assign idle_o = (state_q == dcache_pkg::IDLE);

    assign meta.index      = cur_index;
    assign meta.lookup_tag = req_tag_i;
    assign meta.fill       = (state_q == dcache_pkg::ALLOCATE) && mem_ready_i;
    assign meta.mark_dirty = (state_q == dcache_pkg::WRITE_IN);
    assign meta.clean      = (state_q == dcache_pkg::FLUSH) && victim_dirty && mem_ready_i;

    assign lines.index    = cur_index;
    assign lines.fill_we  = meta.fill;
    assign lines.merge_we = (state_q == dcache_pkg::WRITE_IN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                // resp_ready_o guard keeps a just-served request from restarting
                if (req_valid_i && !resp_ready_o) begin
                    state_d = req_fence_i ? dcache_pkg::FLUSH_NEXT : dcache_pkg::COMPARE;
                end
            end
            dcache_pkg::COMPARE: begin
                if (meta.hit) begin
                    state_d = dcache_pkg::READ_OUT;
                end else if (victim_dirty) begin
                    state_d = dcache_pkg::WRITE_BACK;
                end else begin
                    state_d = dcache_pkg::ALLOCATE;
                end
            end
            dcache_pkg::READ_OUT:   state_d = req_we_i ? dcache_pkg::WRITE_IN : dcache_pkg::IDLE;
            dcache_pkg::WRITE_IN:   state_d = dcache_pkg::IDLE;
            dcache_pkg::WRITE_BACK: if (mem_ready_i) state_d = dcache_pkg::ALLOCATE;
            dcache_pkg::ALLOCATE:   if (mem_ready_i) state_d = dcache_pkg::COMPARE;
            dcache_pkg::FLUSH: begin
                if (line_done) begin
                    state_d = walk_last ? dcache_pkg::IDLE : dcache_pkg::FLUSH_NEXT;
                end
            end
            dcache_pkg::FLUSH_NEXT: state_d = dcache_pkg::FLUSH;
            default:                state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // wraps back to 0 after the last line
    always_ff @(posedge clk) begin
        if (rst) begin
            walk_cnt <= '0;
        end else if (state_q == dcache_pkg::FLUSH && line_done) begin
            walk_cnt <= walk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_ready_o <= 1'b0;
        end else begin
            resp_ready_o <= (state_q == dcache_pkg::READ_OUT) ||
                            (state_q == dcache_pkg::FLUSH && line_done && walk_last);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::READ_OUT) begin
            resp_rdata_o <= lines.word_rdata;
        end
    end

    // memory request, held until the ready pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid_o <= 1'b0;
            mem_we_o    <= 1'b0;
        end else if (state_q == dcache_pkg::ALLOCATE && !mem_ready_i) begin
            mem_valid_o <= 1'b1;
            mem_we_o    <= 1'b0;
        end else if ((state_q == dcache_pkg::WRITE_BACK && !mem_ready_i) ||
                     (state_q == dcache_pkg::FLUSH && victim_dirty && !mem_ready_i)) begin
            mem_valid_o <= 1'b1;
            mem_we_o    <= 1'b1;
        end else begin
            mem_valid_o <= 1'b0;
            mem_we_o    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::ALLOCATE) begin
            mem_addr_o <= {req_tag_i, cur_index, {`DC_OFFSET_W{1'b0}}};
        end else if (state_q == dcache_pkg::WRITE_BACK || state_q == dcache_pkg::FLUSH) begin
            mem_addr_o  <= {meta.victim_tag, cur_index, {`DC_OFFSET_W{1'b0}}};
            mem_wdata_o <= lines.line_rdata; // victim line
        end
    end

endmodule

`default_nettype wire

/* source/dcache_data_array.sv */
// line storage in four banks; write data is either a whole fill line or the old line with one word merged
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_data_array (
    input  wire logic               clk,
    line_if.array                   lines,
    input  wire dcache_pkg::word_t  wdata_i,
    input  wire dcache_pkg::wmask_t wmask_i,
    input  wire logic               word_sel_i,
    input  wire dcache_pkg::line_t  fill_line_i
);

    localparam int BANK_SEL_W  = $clog2(`DC_BANKS);
    localparam int BANK_ADDR_W = $clog2(`DC_BANK_DEPTH);

    logic [BANK_SEL_W-1:0]  bank_sel;
    logic [BANK_SEL_W-1:0]  sel_q;
    logic [BANK_ADDR_W-1:0] bank_addr;
    logic                   write_en;
    dcache_pkg::line_t      merged;
    dcache_pkg::line_t      bank_wdata;
    dcache_pkg::line_t      bank_rdata [`DC_BANKS];

    assign bank_sel  = lines.index[`DC_INDEX_W-1 -: BANK_SEL_W];
    assign bank_addr = lines.index[BANK_ADDR_W-1:0];
    assign write_en  = lines.fill_we || lines.merge_we;

    // bank select follows the registered read
    always_ff @(posedge clk) begin
        sel_q <= bank_sel;
    end

    assign lines.line_rdata = bank_rdata[sel_q];
    assign lines.word_rdata = word_sel_i ? lines.line_rdata[`DC_LINE_W-1 -: `DC_WORD_W]
                                         : lines.line_rdata[`DC_WORD_W-1:0];

    // replace masked bytes in the selected half
    always_comb begin
        merged = lines.line_rdata;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (wmask_i[b]) begin
                merged[word_sel_i * `DC_WORD_W + b * 8 +: 8] = wdata_i[b * 8 +: 8];
            end
        end
    end

    assign bank_wdata = lines.fill_we ? fill_line_i : merged;

    for (genvar g = 0; g < `DC_BANKS; g++) begin : g_bank
        dcache_sram_bank u_bank (
            .clk     (clk),
            .we_i    (write_en && (bank_sel == g)),
            .addr_i  (bank_addr),
            .wdata_i (bank_wdata),
            .rdata_o (bank_rdata[g])
        );
    end

endmodule

`default_nettype wire

/* source/dcache_defines.svh */
// fixed geometry: 64-bit address split 52/8/4, four banks of 64 lines; not meant to be retuned
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address split
`define DC_ADDR_W      64
`define DC_TAG_W       52
`define DC_INDEX_W     8
`define DC_OFFSET_W    4

// data widths
`define DC_WORD_W      64
`define DC_LINE_W      128

// storage layout, index[7:6] picks the bank
`define DC_NLINES      256
`define DC_BANK_DEPTH  64
`define DC_BANKS       4

`endif

/* source/dcache_ifs.sv */
// controller-side bundles for tag lookup and line access; no clock, all strobes are single-cycle
`timescale 1ns/1ps
`default_nettype none

interface meta_if;

    dcache_pkg::index_t index;
    dcache_pkg::tag_t   lookup_tag;
    logic               fill;       // set valid, write tag, clear dirty
    logic               mark_dirty;
    logic               clean;
    logic               hit;
    logic               victim_valid;
    logic               victim_dirty;
    dcache_pkg::tag_t   victim_tag;

    modport ctrl (
        output index, lookup_tag, fill, mark_dirty, clean,
        input  hit, victim_valid, victim_dirty, victim_tag
    );

    modport store (
        input  index, lookup_tag, fill, mark_dirty, clean,
        output hit, victim_valid, victim_dirty, victim_tag
    );

endinterface

interface line_if;

    dcache_pkg::index_t index;
    logic               fill_we;
    logic               merge_we;
    dcache_pkg::line_t  line_rdata; // registered, follows index by one cycle
    dcache_pkg::word_t  word_rdata;

    modport ctrl (
        output index, fill_we, merge_we,
        input  line_rdata, word_rdata
    );

    modport array (
        input  index, fill_we, merge_we,
        output line_rdata, word_rdata
    );

endinterface

`default_nettype wire

/* source/dcache_pkg.sv */
// shared vector types and controller states; widths come from the defines header
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]    addr_t;
    typedef logic [`DC_WORD_W-1:0]    word_t;
    typedef logic [`DC_LINE_W-1:0]    line_t;
    typedef logic [`DC_TAG_W-1:0]     tag_t;
    typedef logic [`DC_INDEX_W-1:0]   index_t;
    typedef logic [`DC_WORD_W/8-1:0]  wmask_t; // one bit per byte

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        READ_OUT,
        WRITE_IN,
        WRITE_BACK,
        ALLOCATE,
        FLUSH,      // one line of the fence walk
        FLUSH_NEXT  // sram read latency between lines
    } ctrl_state_e;

endpackage

`default_nettype wire

/* source/dcache_sram_bank.sv */
// behavioral single-port sram, no enable; read returns old data when written in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_sram_bank (
    input  wire logic                              clk,
    input  wire logic                              we_i,
    input  wire logic [$clog2(`DC_BANK_DEPTH)-1:0] addr_i,
    input  wire dcache_pkg::line_t                 wdata_i,
    output      dcache_pkg::line_t                 rdata_o
);

    dcache_pkg::line_t mem_q [`DC_BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        rdata_o <= mem_q[addr_i]; // every cycle
    end

endmodule

`default_nettype wire

/* source/dcache_tag_store.sv */
// direct-mapped metadata for 256 lines; lookup is combinational on the current index
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_tag_store (
    input  wire logic  clk,
    input  wire logic  rst,
    meta_if.store      meta
);

    logic             valid_q [`DC_NLINES];
    logic             dirty_q [`DC_NLINES];
    dcache_pkg::tag_t tag_q   [`DC_NLINES];

    assign meta.victim_valid = valid_q[meta.index];
    assign meta.victim_dirty = dirty_q[meta.index];
    assign meta.victim_tag   = tag_q[meta.index];
    assign meta.hit          = valid_q[meta.index] && (tag_q[meta.index] == meta.lookup_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DC_NLINES; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end else begin
            if (meta.fill) begin
                valid_q[meta.index] <= 1'b1;
                dirty_q[meta.index] <= 1'b0; // fresh from memory
            end else if (meta.mark_dirty) begin
                dirty_q[meta.index] <= 1'b1;
            end else if (meta.clean) begin
                dirty_q[meta.index] <= 1'b0;
            end
        end
    end

    // only meaningful once valid is set
    always_ff @(posedge clk) begin
        if (meta.fill) begin
            tag_q[meta.index] <= meta.lookup_tag;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
// write-back direct-mapped data cache, 256 x 16 B; one outstanding request on each side
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top (
    input  wire logic               clk,
    input  wire logic               rst,
    // processor side
    input  wire logic               req_valid_i,
    input  wire logic               req_we_i,
    input  wire logic               req_fence_i,
    input  wire dcache_pkg::addr_t  req_addr_i,
    input  wire dcache_pkg::word_t  req_wdata_i,
    input  wire dcache_pkg::wmask_t req_wmask_i,
    output      logic               resp_ready_o,
    output      dcache_pkg::word_t  resp_rdata_o,
    output      logic               idle_o,
    // memory side
    output      logic               mem_valid_o,
    output      logic               mem_we_o,
    output      dcache_pkg::addr_t  mem_addr_o,
    output      dcache_pkg::line_t  mem_wdata_o,
    input  wire logic               mem_ready_i,
    input  wire dcache_pkg::line_t  mem_rdata_i
);

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::index_t req_index;
    logic               word_sel;

    assign req_tag   = req_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_index = req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word_sel  = req_addr_i[`DC_OFFSET_W-1]; // upper or lower word of the line

    meta_if u_meta ();
    line_if u_line ();

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_fence_i  (req_fence_i),
        .req_tag_i    (req_tag),
        .req_index_i  (req_index),
        .resp_ready_o (resp_ready_o),
        .resp_rdata_o (resp_rdata_o),
        .idle_o       (idle_o),
        .mem_valid_o  (mem_valid_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .meta         (u_meta.ctrl),
        .lines        (u_line.ctrl)
    );

    dcache_tag_store u_tags (
        .clk  (clk),
        .rst  (rst),
        .meta (u_meta.store)
    );

    dcache_data_array u_data (
        .clk         (clk),
        .lines       (u_line.array),
        .wdata_i     (req_wdata_i),
        .wmask_i     (req_wmask_i),
        .word_sel_i  (word_sel),
        .fill_line_i (mem_rdata_i)
    );

endmodule

`default_nettype wire
